// ==== build.f ====
+incdir+hw
hw/ec_time_pkg.sv
hw/event_queue.sv
hw/lap_divider.sv
hw/lap_multiplier.sv
hw/ec_time_to_sys_time.sv
hw/ec_time_unit.sv
testbench/tb_ec_time_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status follows the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_ec_time_unit -f build.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Result: PASSED$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== testbench/tb_ec_time_unit.sv ====
`timescale 1ns/1ps
`include "ec_time_params.svh"

module tb_ec_time_unit;

  import ec_time_pkg::*;

  localparam int DEPTH = `EC_QUEUE_DEPTH;
  localparam int N_EVENTS = 46; // 10 single, 6 short burst, 10 sweep, 20 overflow burst.
  localparam int WATCHDOG_CYCLES = N_EVENTS * 100 + 1000;
  localparam ufreq_mult_t SWEEP [5] = '{9'd0, 9'd511, 9'd1, 9'd256, 9'd255};

  logic CLK;
  logic reset;
  ec_time_t ec_time;
  logic ec_valid;
  ufreq_mult_t ufreq_mult;
  sys_result_t result;
  logic overflow;

  logic [31:0] lfsr;
  sys_time_t expected_q [$];
  int received;
  int value_errs;
  int other_errs;
  string test_name;

  ec_time_unit dut_i (
    .CLK        (CLK),
    .reset      (reset),
    .ec_time    (ec_time),
    .ec_valid   (ec_valid),
    .ufreq_mult (ufreq_mult),
    .result     (result),
    .overflow   (overflow)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [63:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[62:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Lap count is the floor of ns over the 31250 ns lap, cut to 47 bits.
  function automatic sys_time_t model_sys_time(input ec_time_t ts, input ufreq_mult_t m);
    logic [63:0] laps;
    logic [46:0] lap;
    laps = ts / 64'd31250;
    lap = laps[46:0];
    return 56'(lap) * 56'(m);
  endfunction

  task automatic apply_reset();
    reset = 1'b1;
    ec_valid = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
    reset = 1'b0;
  endtask

  task automatic push_event(input ec_time_t ts);
    ec_valid = 1'b1;
    ec_time = ts;
    expected_q.push_back(model_sys_time(ts, ufreq_mult));
    @(posedge CLK);
    #2;
    ec_valid = 1'b0;
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (expected_q.size() != 0 && n < max_cycles) begin
      @(posedge CLK);
      n++;
    end
    assert (expected_q.size() == 0) else begin
      $display("Test %s: %0d results never arrived", test_name, expected_q.size());
      other_errs++;
      expected_q.delete();
    end
    #2;
  endtask

  task automatic single_event(input ec_time_t ts);
    logic [63:0] gap;
    push_event(ts);
    wait_drained(100);
    take_bits(4, gap);
    repeat (8 + int'(gap[3:0])) @(posedge CLK); // Keeps events more than 80 cycles apart.
    #2;
  endtask

  task automatic check_overflow(input logic want);
    assert (overflow == want) else begin
      $display("ERR %s: expected overflow %b, actual %b", test_name, want, overflow);
      value_errs++;
    end
  endtask

  always @(negedge CLK) begin : check_results
    sys_time_t want;
    if (!reset && result.valid) begin
      received++;
      assert (expected_q.size() != 0) else begin
        $display("Test %s: result %h arrived with no event pending", test_name,
                 result.sys_time);
        other_errs++;
      end
      if (expected_q.size() != 0) begin
        want = expected_q.pop_front();
        assert (result.sys_time == want) else begin
          $display("ERR %s: expected %h, actual %h", test_name, want, result.sys_time);
          value_errs++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    logic [63:0] r;
    int base;
    int n;
    lfsr = 32'h9bda;
    reset = 1'b1;
    ec_time = '0;
    ec_valid = 1'b0;
    ufreq_mult = '0;
    received = 0;
    value_errs = 0;
    other_errs = 0;
    apply_reset();

    test_name = "idle_after_reset";
    repeat (20) begin
      @(negedge CLK);
      assert (!result.valid && !overflow) else begin
        $display("ERR %s: expected valid 0 overflow 0, actual valid %b overflow %b",
                 test_name, result.valid, overflow);
        value_errs++;
      end
    end
    @(posedge CLK);
    #2;

    test_name = "single_events";
    take_bits(9, r);
    ufreq_mult = r[8:0];
    single_event(64'd0);
    single_event(64'd31249);
    single_event(64'd31250);
    take_bits(32, r);
    single_event(64'd31250 * r); // Exact multiple of the lap.
    take_bits(14, r);
    single_event(r);
    take_bits(63, r);
    single_event({1'b1, r[62:0]});
    take_bits(63, r);
    single_event({1'b1, r[62:0]});
    single_event('1);
    repeat (2) begin
      take_bits(64, r);
      single_event(r);
    end
    check_overflow(1'b0);

    test_name = "short_burst";
    take_bits(9, r);
    ufreq_mult = r[8:0];
    repeat (6) begin
      take_bits(64, r);
      push_event(r);
    end
    wait_drained(600);
    check_overflow(1'b0);

    test_name = "mult_sweep";
    for (int i = 0; i < 5; i++) begin
      ufreq_mult = SWEEP[i];
      take_bits(64, r);
      single_event(r);
    end
    repeat (5) begin
      take_bits(9, r);
      ufreq_mult = r[8:0];
      take_bits(64, r);
      single_event(r);
    end
    check_overflow(1'b0);

    // Converter is idle here, so only the first DEPTH+1 events fit.
    test_name = "overflow_burst";
    take_bits(9, r);
    ufreq_mult = r[8:0];
    base = received;
    repeat (20) begin
      take_bits(64, r);
      push_event(r);
    end
    n = 0;
    while (received - base < DEPTH + 1 && n < (DEPTH + 2) * 100) begin
      @(posedge CLK);
      n++;
    end
    #2;
    check_overflow(1'b1);
    repeat (100) @(posedge CLK); // Window for one more result.
    #2;
    assert (received - base >= DEPTH + 1 && received - base <= DEPTH + 2) else begin
      $display("ERR %s: expected %0d to %0d results, actual %0d", test_name,
               DEPTH + 1, DEPTH + 2, received - base);
      value_errs++;
    end
    expected_q.delete();
    check_overflow(1'b1);

    test_name = "overflow_cleared";
    apply_reset();
    check_overflow(1'b0);

    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/ec_time_unit.sv ====
`timescale 1ns/1ps
`include "ec_time_params.svh"

module ec_time_unit (
  input  logic                     CLK,
  input  logic                     reset,
  input  ec_time_pkg::ec_time_t    ec_time,
  input  logic                     ec_valid,
  input  ec_time_pkg::ufreq_mult_t ufreq_mult,
  output ec_time_pkg::sys_result_t result,
  output logic                     overflow
);

  import ec_time_pkg::*;

  ec_time_t queue_head;
  logic queue_not_empty;
  logic queue_pop;

  // Absorbs capture bursts while a conversion runs.
  event_queue #(
    .payload_t (ec_time_t),
    .DEPTH     (`EC_QUEUE_DEPTH)
  ) queue_i (
    .CLK       (CLK),
    .reset     (reset),
    .push      (ec_valid),
    .push_data (ec_time),
    .pop       (queue_pop),
    .head      (queue_head),
    .not_empty (queue_not_empty),
    .overflow  (overflow)
  );

  ec_time_to_sys_time conv_i (
    .CLK             (CLK),
    .reset           (reset),
    .queue_head      (queue_head),
    .queue_not_empty (queue_not_empty),
    .ufreq_mult      (ufreq_mult),
    .queue_pop       (queue_pop),
    .result          (result)
  );

endmodule

// ==== hw/ec_time_to_sys_time.sv ====
`timescale 1ns/1ps
`include "ec_time_params.svh"

module ec_time_to_sys_time (
  input  logic                     CLK,
  input  logic                     reset,
  input  ec_time_pkg::ec_time_t    queue_head,
  input  logic                     queue_not_empty,
  input  ec_time_pkg::ufreq_mult_t ufreq_mult,
  output logic                     queue_pop,
  output ec_time_pkg::sys_result_t result
);

  import ec_time_pkg::*;

  localparam int MULT_LATENCY = `EC_MULT_LATENCY;
  localparam int CNT_W = $clog2(MULT_LATENCY);

  typedef enum logic [1:0] {
    WAIT,
    LOAD,
    DIV_WAIT,
    MULT_WAIT
  } state_t;

  state_t state;
  ec_time_t ts;
  logic din_valid;
  logic din_ready;
  logic div_dout_valid;
  ec_time_t quotient;
  sys_time_t product;
  logic [CNT_W-1:0] mult_cnt;
  logic result_valid;

  assign queue_pop = (state == WAIT) && queue_not_empty;
  assign result = '{valid: result_valid, sys_time: product};

  lap_divider div_i (
    .CLK        (CLK),
    .reset      (reset),
    .din_valid  (din_valid),
    .dividend   (ts),
    .din_ready  (din_ready),
    .dout_valid (div_dout_valid),
    .quotient   (quotient)
  );

  // Quotient is held until the next division, so the pipeline settles on it.
  lap_multiplier mult_i (
    .CLK        (CLK),
    .reset      (reset),
    .lap        (quotient[$bits(lap_t)-1:0]),
    .ufreq_mult (ufreq_mult),
    .product    (product)
  );

  always_ff @(posedge CLK) begin
    if (queue_pop) begin
      ts <= queue_head;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= WAIT;
      din_valid <= 1'b0;
      mult_cnt <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      case (state)
        WAIT: begin
          if (queue_pop) begin
            din_valid <= 1'b1;
            state <= LOAD;
          end
        end
        LOAD: begin
          if (din_ready) begin
            din_valid <= 1'b0; // Transfer happens on this edge.
            state <= DIV_WAIT;
          end
        end
        DIV_WAIT: begin
          if (div_dout_valid) begin
            mult_cnt <= CNT_W'(1); // Quotient cycle is the first stage.
            state <= MULT_WAIT;
          end
        end
        MULT_WAIT: begin
          if (mult_cnt == CNT_W'(MULT_LATENCY - 1)) begin
            result_valid <= 1'b1; // Lines up with the product leaving stage 5.
            state <= WAIT;
          end else begin
            mult_cnt <= mult_cnt + 1'b1;
          end
        end
        default: state <= WAIT;
      endcase
    end
  end

  // Only one division is ever in flight, owned by this FSM.
  a_quotient_in_div_wait : assert property (
    @(posedge CLK) disable iff (reset) div_dout_valid |-> (state == DIV_WAIT)
  ) else $error("ec_time_to_sys_time: quotient outside DIV_WAIT");

endmodule

// ==== hw/lap_multiplier.sv ====
`timescale 1ns/1ps

module lap_multiplier (
  input  logic                     CLK,
  input  logic                     reset,
  input  ec_time_pkg::lap_t        lap,
  input  ec_time_pkg::ufreq_mult_t ufreq_mult,
  output ec_time_pkg::sys_time_t   product
);

  import ec_time_pkg::*;

  localparam int PP_W = $bits(lap_t) + 4;

  typedef struct packed {
    lap_t        a;
    ufreq_mult_t b;
  } operands_t;

  typedef struct packed {
    logic [PP_W-1:0] lo;  // a * b[3:0].
    logic [PP_W-1:0] mid; // a * b[7:4].
    lap_t            hi;  // a when b[8] is set.
  } partials_t;

  typedef struct packed {
    sys_time_t sum;
    lap_t      hi;
  } partial_sum_t;

  operands_t s1;
  partials_t s2;
  partial_sum_t s3;
  sys_time_t s4;
  sys_time_t s5;

  assign product = s5;

  always_ff @(posedge CLK) begin
    if (reset) begin
      s1 <= '0;
      s2 <= '0;
      s3 <= '0;
      s4 <= '0;
      s5 <= '0;
    end else begin
      s1 <= '{a: lap, b: ufreq_mult};
      s2.lo <= PP_W'(s1.a) * PP_W'(s1.b[3:0]);
      s2.mid <= PP_W'(s1.a) * PP_W'(s1.b[7:4]);
      s2.hi <= s1.b[8] ? s1.a : '0;
      s3.sum <= sys_time_t'(s2.lo) + (sys_time_t'(s2.mid) << 4);
      s3.hi <= s2.hi;
      s4 <= s3.sum + (sys_time_t'(s3.hi) << 8); // 47 x 9 bits fits 56 exactly.
      s5 <= s4;
    end
  end

endmodule

// ==== hw/lap_divider.sv ====
`timescale 1ns/1ps
`include "ec_time_params.svh"

module lap_divider (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  din_valid,
  input  ec_time_pkg::ec_time_t dividend,
  output logic                  din_ready,
  output logic                  dout_valid,
  output ec_time_pkg::ec_time_t quotient
);

  import ec_time_pkg::*;

  localparam int DIV_W = `EC_LAP_DIVISOR_W;
  localparam logic [DIV_W-1:0] DIVISOR = `EC_LAP_DIVISOR;
  localparam int STEPS = $bits(ec_time_t);
  localparam int STEP_W = $clog2(STEPS + 1);

  logic busy;
  logic [STEP_W-1:0] step;
  ec_time_t work; // Dividend shifts out the top, quotient bits shift in below.
  logic [DIV_W-1:0] rem;
  logic [DIV_W:0] trial;
  logic [DIV_W:0] diff;
  logic fits;
  logic load;
  logic iterate;
  logic finish;

  assign din_ready = !busy;
  assign load = din_valid && !busy;
  assign iterate = busy && (step != STEP_W'(STEPS));
  assign finish = busy && (step == STEP_W'(STEPS));

  // One restoring step.
  assign trial = {rem, work[STEPS-1]};
  assign diff = trial - {1'b0, DIVISOR};
  assign fits = (trial >= {1'b0, DIVISOR});

  always_ff @(posedge CLK) begin
    if (reset) begin
      busy <= 1'b0;
      step <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= 1'b0;
      if (load) begin
        busy <= 1'b1;
        step <= '0;
      end else if (iterate) begin
        step <= step + 1'b1;
      end else if (finish) begin
        busy <= 1'b0;
        dout_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      work <= dividend;
      rem <= '0;
    end else if (iterate) begin
      work <= {work[STEPS-2:0], fits};
      // Remainder stays below the divisor, so the top bit is never needed.
      rem <= fits ? diff[DIV_W-1:0] : trial[DIV_W-1:0];
    end
  end

  always_ff @(posedge CLK) begin
    if (finish) begin
      quotient <= work;
    end
  end

  // Accepted operand blocks new input for the whole division,
  // and the quotient arrives exactly 65 cycles after the transfer.
  a_busy_until_done : assert property (
    @(posedge CLK) disable iff (reset)
    (din_valid && din_ready) |=> !din_ready [*65] ##1 (dout_valid && din_ready)
  ) else $error("lap_divider: ready or result timing broken");

endmodule

// ==== hw/event_queue.sv ====
`timescale 1ns/1ps
`include "ec_time_params.svh"

module event_queue #(
  parameter type payload_t = logic [63:0],
  parameter int DEPTH = `EC_QUEUE_DEPTH
) (
  input  logic     CLK,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     overflow
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic full;
  logic wr_en;
  logic rd_en;

  assign full = (count == CNT_W'(DEPTH));
  assign not_empty = (count != '0);
  assign wr_en = push && !full;
  assign rd_en = pop && not_empty;
  assign head = mem[rd_ptr]; // Head is visible as soon as not_empty rises.

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH.
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push && full) begin
        overflow <= 1'b1; // Sticky until reset.
      end
    end
  end

  // The consumer only pops what it has seen as present.
  a_no_pop_when_empty : assert property (
    @(posedge CLK) disable iff (reset) pop |-> not_empty
  ) else $error("event_queue: pop while empty");

  a_count_bound : assert property (
    @(posedge CLK) disable iff (reset) count <= CNT_W'(DEPTH)
  ) else $error("event_queue: occupancy above DEPTH");

endmodule

// ==== hw/ec_time_pkg.sv ====
package ec_time_pkg;

  localparam int EC_TIME_W = 64;
  localparam int LAP_W = 47;
  localparam int UFREQ_MULT_W = 9;
  localparam int SYS_TIME_W = 56;

  // Distributed-clock timestamp in ns.
  typedef logic [EC_TIME_W-1:0] ec_time_t;

  // Lap count as seen by the multiplier.
  typedef logic [LAP_W-1:0] lap_t;

  // System clock multiplier per lap.
  typedef logic [UFREQ_MULT_W-1:0] ufreq_mult_t;

  typedef logic [SYS_TIME_W-1:0] sys_time_t;

  // Converter output; valid pulses for one cycle per conversion.
  typedef struct packed {
    logic      valid;
    sys_time_t sys_time;
  } sys_result_t;

endpackage

// ==== hw/ec_time_params.svh ====
`ifndef EC_TIME_PARAMS_SVH
`define EC_TIME_PARAMS_SVH

// Lap period of the distributed clock, in ns.
`define EC_LAP_DIVISOR_W 16
`define EC_LAP_DIVISOR 16'd31250

// Pipeline depth of the lap multiplier.
`define EC_MULT_LATENCY 5

// Capture events held while a conversion runs. Must be a power of two.
`define EC_QUEUE_DEPTH 8

`endif
